/* logic/dwnld_decoder.sv */
// download stream decoder
// drops the header, splits the stream into SDRAM banks and the PROM
// and registers word address, byte mask and write strobes

`timescale 1ns/100ps
`include "rom_loader_defs.svh"

module dwnld_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    input  rom_loader_pkg::ioctl_addr_t ioctl_addr,
    input  rom_loader_pkg::byte_t       ioctl_data,
    input  logic                        ioctl_wr,
    input  logic                        sdram_ack,
    output rom_loader_pkg::prog_req_t   prog_req,
    output logic                        prog_we,
    output logic                        prom_we,
    output rom_loader_pkg::prog_addr_t  prom_addr,
    output rom_loader_pkg::byte_t       prom_data
);

    rom_loader_pkg::ioctl_addr_t part_addr;
    rom_loader_pkg::ioctl_addr_t offset;
    rom_loader_pkg::ioctl_addr_t eff_addr;
    rom_loader_pkg::bank_t       bank;
    logic                        header;
    logic                        is_prom;
    logic                        accept;

    //////////////////////////////////////////////////
    // address decoding

    always_comb begin
        // addresses are counted from the first byte after the header
        header    = ioctl_addr < `DWNLD_HEADER;
        part_addr = ioctl_addr - `DWNLD_HEADER;
        is_prom   = part_addr >= `DWNLD_PROM_START;
    end

    always_comb begin
        // highest bank whose start is not above the part address wins
        if (part_addr >= `DWNLD_BA3_START) begin
            bank = 2'd3;
        end else if (part_addr >= `DWNLD_BA2_START) begin
            bank = 2'd2;
        end else if (part_addr >= `DWNLD_BA1_START) begin
            bank = 2'd1;
        end else begin
            bank = 2'd0;
        end
        case (bank)
            2'd1:    offset = `DWNLD_BA1_START;
            2'd2:    offset = `DWNLD_BA2_START;
            2'd3:    offset = `DWNLD_BA3_START;
            default: offset = '0;
        endcase
        // byte address inside the selected bank
        eff_addr = part_addr - offset;
    end

    // bytes seen outside the download window or inside the header are lost
    assign accept = ioctl_wr && downloading && !header;

    //////////////////////////////////////////////////
    // write strobes

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else if (accept) begin
            // a new byte replaces whatever SDRAM request is still pending
            prog_we <= !is_prom;
            prom_we <= is_prom;
        end else begin
            // the PROM strobe lives for one cycle only
            prom_we <= 1'b0;
            if (!downloading || sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // request payload

    always_ff @(posedge clk) begin
        if (accept) begin
            if (is_prom) begin
                // the PROM store keeps only the low bits of this address
                prom_addr <= part_addr[21:0];
                prom_data <= ioctl_data;
            end else begin
                // bit 0 selects the byte lane, the rest is the word address
                prog_req.addr <= eff_addr[22:1];
                prog_req.ba   <= bank;
                prog_req.mask <= (eff_addr[0] ^ `DWNLD_SWAB) ? 2'b01 : 2'b10;
                prog_req.data <= {2{ioctl_data}};
            end
        end
    end

endmodule

/* logic/prom_store.sv */
// PROM byte memory at the end of the download stream
// written by the decoder's prom_we pulse, read through a registered port

`timescale 1ns/100ps
`include "rom_loader_defs.svh"

module prom_store (
    input  logic                       clk,
    input  logic                       prom_we,
    input  rom_loader_pkg::prog_addr_t prom_addr,
    input  rom_loader_pkg::byte_t      prom_data,
    input  logic [`PROM_AW-1:0]        prom_rd_addr,
    output rom_loader_pkg::byte_t      prom_rd_data
);

    localparam int DEPTH = 1 << `PROM_AW;

    rom_loader_pkg::byte_t mem [DEPTH];
    logic [`PROM_AW-1:0]   wr_addr;

    // the PROM region starts on a 256-byte boundary, so the low bits
    // of the part address are already the offset into the PROM
    assign wr_addr = prom_addr[`PROM_AW-1:0];

    always_ff @(posedge clk) begin
        if (prom_we) begin
            mem[wr_addr] <= prom_data;
        end
    end

    // one cycle read latency, same as the SDRAM stand-in
    always_ff @(posedge clk) begin
        prom_rd_data <= mem[prom_rd_addr];
    end

endmodule

/* logic/rom_loader_defs.svh */
// shared constants of the ROM download path
// header length, region starts and the byte swap option of the decoder
// memory sizes and ack latency of the on-chip storage stand-ins

`ifndef ROM_LOADER_DEFS_SVH
`define ROM_LOADER_DEFS_SVH

// leading bytes of the stream that carry no ROM data
`define DWNLD_HEADER      25'd16

// part-address starts of SDRAM banks 1 to 3, bank 0 starts at zero
`define DWNLD_BA1_START   25'h400
`define DWNLD_BA2_START   25'h800
`define DWNLD_BA3_START   25'hC00

// everything from here to the end of the stream goes to the PROM
`define DWNLD_PROM_START  25'h1000

// swaps every pair of bytes on their way into SDRAM
`define DWNLD_SWAB        1'b0

`define SDRAM_WORD_AW     9
`define PROM_AW           8
`define SDRAM_ACK_LAT     3

`endif

/* logic/rom_loader_pkg.sv */
// types shared by the ROM download path
// width typedefs, the SDRAM write request and the port FSM states

package rom_loader_pkg;

    typedef logic [24:0] ioctl_addr_t;
    typedef logic [21:0] prog_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [1:0]  bank_t;
    // active low, bit 0 guards the low byte
    typedef logic [1:0]  mask_t;

    // one SDRAM programming request, the data byte is repeated on both lanes
    typedef struct packed {
        prog_addr_t addr;
        bank_t      ba;
        mask_t      mask;
        word_t      data;
    } prog_req_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } port_state_t;

endpackage

/* logic/rom_loader_top.sv */
// top level of the ROM download path
// decoder feeding the SDRAM bank port and the PROM store
// readback ports of both stores are brought out for checking

`timescale 1ns/100ps
`include "rom_loader_defs.svh"

module rom_loader_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    input  rom_loader_pkg::ioctl_addr_t ioctl_addr,
    input  rom_loader_pkg::byte_t       ioctl_data,
    input  logic                        ioctl_wr,
    input  rom_loader_pkg::bank_t       rd_ba,
    input  logic [`SDRAM_WORD_AW-1:0]   rd_addr,
    input  logic [`PROM_AW-1:0]         prom_rd_addr,
    output rom_loader_pkg::word_t       rd_data,
    output rom_loader_pkg::byte_t       prom_rd_data,
    output logic                        prog_busy
);

    rom_loader_pkg::prog_req_t  prog_req;
    rom_loader_pkg::prog_addr_t prom_addr;
    rom_loader_pkg::byte_t      prom_data;
    logic                       sdram_ack;
    logic                       prom_we;

    // prog_busy is the decoder's prog_we, high while an SDRAM write is pending
    dwnld_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_req    (prog_req),
        .prog_we     (prog_busy),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data)
    );

    sdram_bank_port u_sdram (
        .clk       (clk),
        .rst       (rst),
        .prog_req  (prog_req),
        .prog_we   (prog_busy),
        .sdram_ack (sdram_ack),
        .rd_ba     (rd_ba),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    prom_store u_prom (
        .clk          (clk),
        .prom_we      (prom_we),
        .prom_addr    (prom_addr),
        .prom_data    (prom_data),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data)
    );

endmodule

/* logic/sdram_bank_port.sv */
// on-chip stand-in for the SDRAM programming port
// four banks of 16-bit words with byte-masked writes
// each request is acknowledged a fixed number of cycles after it is taken

`timescale 1ns/100ps
`include "rom_loader_defs.svh"

module sdram_bank_port (
    input  logic                          clk,
    input  logic                          rst,
    input  rom_loader_pkg::prog_req_t     prog_req,
    input  logic                          prog_we,
    output logic                          sdram_ack,
    input  rom_loader_pkg::bank_t         rd_ba,
    input  logic [`SDRAM_WORD_AW-1:0]     rd_addr,
    output rom_loader_pkg::word_t         rd_data
);

    localparam int DEPTH = 4 << `SDRAM_WORD_AW;
    localparam int CNT_W = $clog2(`SDRAM_ACK_LAT + 1);

    // banks are stacked one above the other, the bank number is the top index bits
    rom_loader_pkg::word_t       mem [DEPTH];
    rom_loader_pkg::port_state_t state;
    rom_loader_pkg::prog_req_t   req;
    logic [CNT_W-1:0]            cnt;
    logic [`SDRAM_WORD_AW+1:0]   wr_idx;
    logic                        wr_fire;

    assign wr_idx  = {req.ba, req.addr[`SDRAM_WORD_AW-1:0]};
    // the write lands on the last cycle of the latency count
    assign wr_fire = (state == rom_loader_pkg::BUSY) && (cnt == CNT_W'(`SDRAM_ACK_LAT));

    //////////////////////////////////////////////////
    // request FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= rom_loader_pkg::IDLE;
            cnt       <= '0;
            sdram_ack <= 1'b0;
        end else begin
            sdram_ack <= wr_fire;
            case (state)
                rom_loader_pkg::IDLE: begin
                    if (prog_we) begin
                        state <= rom_loader_pkg::BUSY;
                        cnt   <= CNT_W'(1);
                    end
                end
                rom_loader_pkg::BUSY: begin
                    if (wr_fire) begin
                        state <= rom_loader_pkg::DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // gives the decoder one cycle to drop prog_we after the ack
                rom_loader_pkg::DONE: state <= rom_loader_pkg::IDLE;
                default:              state <= rom_loader_pkg::IDLE;
            endcase
        end
    end

    // the request is held steady while the latency runs out
    always_ff @(posedge clk) begin
        if (state == rom_loader_pkg::IDLE && prog_we) begin
            req <= prog_req;
        end
    end

    //////////////////////////////////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (!req.mask[0]) begin
                mem[wr_idx][7:0] <= req.data[7:0];
            end
            if (!req.mask[1]) begin
                mem[wr_idx][15:8] <= req.data[15:8];
            end
        end
        rd_data <= mem[{rd_ba, rd_addr}];
    end

endmodule

/* rom_loader.f */
+incdir+logic
logic/rom_loader_pkg.sv
logic/dwnld_decoder.sv
logic/sdram_bank_port.sv
logic/prom_store.sv
logic/rom_loader_top.sv
testbench/rom_loader_asserts.sv
testbench/rom_loader_checker.sv
testbench/rom_loader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the ROM loader testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rom_loader_tb \
    -f rom_loader.f \
    --Mdir obj_dir -o sim_rom_loader

# the simulation status is judged from the log, not from its exit code
./obj_dir/sim_rom_loader > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/rom_loader_asserts.sv */
// concurrent assertions on the decoder write strobes
// bound into every dwnld_decoder instance

`timescale 1ns/100ps

module rom_loader_asserts (
    input logic clk,
    input logic rst,
    input logic ioctl_wr,
    input logic prog_we,
    input logic prom_we,
    input logic sdram_ack
);

    // a byte goes either to SDRAM or to the PROM, never to both
    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(prog_we && prom_we)) else $error("prog_we and prom_we high together");

    // the pending SDRAM request ends one cycle after its ack
    a_ack_release: assert property (@(posedge clk) disable iff (rst)
        sdram_ack |=> !prog_we) else $error("prog_we still high after sdram_ack");

    // a new byte during a pending request would replace it
    a_source_spacing: assert property (@(posedge clk) disable iff (rst)
        prog_we |-> !ioctl_wr) else $error("ioctl_wr while prog_we pending");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> (!prog_we && !prom_we)) else $error("strobes not low after reset");

endmodule

bind dwnld_decoder rom_loader_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .ioctl_wr  (ioctl_wr),
    .prog_we   (prog_we),
    .prom_we   (prom_we),
    .sdram_ack (sdram_ack)
);

/* testbench/rom_loader_checker.sv */
// reference model of the ROM loader storage built from the download stream
// compares every readback and the prog_busy window of each SDRAM byte
// keeps the check and error counts

`timescale 1ns/100ps
`include "rom_loader_defs.svh"

module rom_loader_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    input  rom_loader_pkg::ioctl_addr_t ioctl_addr,
    input  rom_loader_pkg::byte_t       ioctl_data,
    input  logic                        ioctl_wr,
    input  logic                        prog_busy,
    input  rom_loader_pkg::bank_t       rd_ba,
    input  logic [`SDRAM_WORD_AW-1:0]   rd_addr,
    input  rom_loader_pkg::word_t       rd_data,
    input  logic [`PROM_AW-1:0]         prom_rd_addr,
    input  rom_loader_pkg::byte_t       prom_rd_data,
    input  logic                        rd_check,
    input  logic                        rd_prom,
    output int                          checks,
    output int                          errors
);

    // edges on which prog_busy is seen high for one SDRAM byte
    // one for the decoder register, the ack latency, and one until the ack is seen
    localparam int BUSY_CYCLES = `SDRAM_ACK_LAT + 2;

    // model words per bank and word with a known flag for each byte lane
    rom_loader_pkg::word_t       sdram_model [4 << `SDRAM_WORD_AW];
    logic [1:0]                  sdram_known [4 << `SDRAM_WORD_AW];
    rom_loader_pkg::byte_t       prom_model [1 << `PROM_AW];
    logic                        prom_known [1 << `PROM_AW];
    logic                        chk_d;
    logic                        prom_d;
    logic [`SDRAM_WORD_AW+1:0]   idx_d;
    logic [`PROM_AW-1:0]         paddr_d;
    logic                        taken;
    logic                        to_sdram;
    int                          busy_left;

    function automatic rom_loader_pkg::ioctl_addr_t region_start(input int b);
        case (b)
            1:       return `DWNLD_BA1_START;
            2:       return `DWNLD_BA2_START;
            3:       return `DWNLD_BA3_START;
            default: return '0;
        endcase
    endfunction

    // a byte counts only inside the download window and past the header
    assign taken    = ioctl_wr && downloading && ioctl_addr >= `DWNLD_HEADER;
    // everything below the PROM start lands in one of the SDRAM banks
    assign to_sdram = (ioctl_addr - `DWNLD_HEADER) < `DWNLD_PROM_START;

    //////////////////////////////////////////////////
    // model update from the stream

    always @(posedge clk) begin
        rom_loader_pkg::ioctl_addr_t part;
        rom_loader_pkg::ioctl_addr_t off;
        int                          b;
        logic [`SDRAM_WORD_AW+1:0]   idx;
        if (rst) begin
            for (int i = 0; i < (4 << `SDRAM_WORD_AW); i++) begin
                sdram_known[i] = 2'b00;
            end
            for (int i = 0; i < (1 << `PROM_AW); i++) begin
                prom_known[i] = 1'b0;
            end
        end else if (taken) begin
            part = ioctl_addr - `DWNLD_HEADER;
            if (!to_sdram) begin
                off = part - `DWNLD_PROM_START;
                prom_model[off[`PROM_AW-1:0]] = ioctl_data;
                prom_known[off[`PROM_AW-1:0]] = 1'b1;
            end else begin
                // pick the highest region whose start the part address has reached
                b = 3;
                while (b > 0 && part < region_start(b)) begin
                    b = b - 1;
                end
                off = part - region_start(b);
                idx = {2'(b), off[`SDRAM_WORD_AW:1]};
                // even offsets fill the low byte and odd offsets the high byte
                if (off[0]) begin
                    sdram_model[idx][15:8] = ioctl_data;
                    sdram_known[idx][1]    = 1'b1;
                end else begin
                    sdram_model[idx][7:0] = ioctl_data;
                    sdram_known[idx][0]   = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // prog_busy window and readback comparison

    // readback data is valid one cycle after its address
    always @(posedge clk) begin
        rom_loader_pkg::word_t mask;
        int                    fails;
        fails = 0;
        if (rst) begin
            chk_d     <= 1'b0;
            busy_left <= 0;
            checks    <= 0;
            errors    <= 0;
        end else begin
            // prog_busy must follow each SDRAM byte for exactly its window
            if (prog_busy !== (busy_left != 0)) begin
                $display("[FAIL] t=%0t prog_busy: got %0b expected %0b",
                         $time, prog_busy, busy_left != 0);
                fails++;
            end
            // a PROM byte or the end of the download drops a pending request
            if (taken) begin
                busy_left <= to_sdram ? BUSY_CYCLES : 0;
            end else if (!downloading) begin
                busy_left <= 0;
            end else if (busy_left != 0) begin
                busy_left <= busy_left - 1;
            end

            if (chk_d && prom_d) begin
                checks <= checks + 1;
                if (!prom_known[paddr_d]) begin
                    $display("[FAIL] t=%0t nothing was written to PROM byte %02h",
                             $time, paddr_d);
                    fails++;
                end else if (prom_rd_data !== prom_model[paddr_d]) begin
                    $display("[FAIL] t=%0t prom_rd_data byte %02h: got %02h expected %02h",
                             $time, paddr_d, prom_rd_data, prom_model[paddr_d]);
                    fails++;
                end else begin
                    $display("test %0d: PROM byte %02h = %02h ok",
                             checks, paddr_d, prom_rd_data);
                end
            end else if (chk_d) begin
                checks <= checks + 1;
                // bytes that were never written are left out of the compare
                mask = {{8{sdram_known[idx_d][1]}}, {8{sdram_known[idx_d][0]}}};
                if (mask == 16'h0000) begin
                    $display("[FAIL] t=%0t nothing was written to bank %0d word %03h",
                             $time, idx_d[`SDRAM_WORD_AW+1:`SDRAM_WORD_AW],
                             idx_d[`SDRAM_WORD_AW-1:0]);
                    fails++;
                end else if (((rd_data ^ sdram_model[idx_d]) & mask) !== 16'h0000) begin
                    $display("[FAIL] t=%0t rd_data bank %0d word %03h: got %04h expected %04h",
                             $time, idx_d[`SDRAM_WORD_AW+1:`SDRAM_WORD_AW],
                             idx_d[`SDRAM_WORD_AW-1:0], rd_data,
                             sdram_model[idx_d] & mask);
                    fails++;
                end else begin
                    $display("test %0d: bank %0d word %03h = %04h ok", checks,
                             idx_d[`SDRAM_WORD_AW+1:`SDRAM_WORD_AW],
                             idx_d[`SDRAM_WORD_AW-1:0], rd_data);
                end
            end
            errors  <= errors + fails;
            chk_d   <= rd_check;
            prom_d  <= rd_prom;
            idx_d   <= {rd_ba, rd_addr};
            paddr_d <= prom_rd_addr;
        end
    end

    task automatic print_summary();
        $display("readback checks %0d, errors %0d", checks, errors);
    endtask

endmodule

/* testbench/rom_loader_tb.sv */
// testbench top for the ROM download path
// clock and reset, download table with LFSR data, readback table

`timescale 1ns/100ps
`include "rom_loader_defs.svh"

module rom_loader_tb;

    localparam int STIM_N     = 21;
    localparam int RB_N       = 12;
    localparam int GAP        = 8;
    localparam int WAIT_LIMIT = 32;

    // download entries as {downloading, ioctl_addr}
    localparam logic [25:0] STIM [STIM_N] = '{
        {1'b1, 25'h1100}, {1'b1, 25'h0000}, {1'b1, 25'h0001}, {1'b1, 25'h000F},
        {1'b1, 25'h0010}, {1'b1, 25'h0011}, {1'b1, 25'h0030}, {1'b1, 25'h0033},
        {1'b1, 25'h0410}, {1'b1, 25'h0411}, {1'b1, 25'h060F}, {1'b1, 25'h0812},
        {1'b1, 25'h0A0E}, {1'b1, 25'h0C10}, {1'b1, 25'h0C11}, {1'b1, 25'h1010},
        {1'b1, 25'h1011}, {1'b1, 25'h110F}, {1'b0, 25'h0030}, {1'b0, 25'h1011},
        {1'b0, 25'h0011}
    };

    // readback entries as {prom, bank, word or byte address}
    localparam logic [11:0] READBACK [RB_N] = '{
        {1'b0, 2'd0, 9'h000}, {1'b0, 2'd0, 9'h010}, {1'b0, 2'd0, 9'h011},
        {1'b0, 2'd1, 9'h000}, {1'b0, 2'd1, 9'h0FF}, {1'b0, 2'd2, 9'h001},
        {1'b0, 2'd2, 9'h0FF}, {1'b0, 2'd3, 9'h000}, {1'b1, 2'd0, 9'h000},
        {1'b1, 2'd0, 9'h001}, {1'b1, 2'd0, 9'h0FF}, {1'b1, 2'd0, 9'h0F0}
    };

    logic                        clk;
    logic                        rst;
    logic                        downloading;
    rom_loader_pkg::ioctl_addr_t ioctl_addr;
    rom_loader_pkg::byte_t       ioctl_data;
    logic                        ioctl_wr;
    rom_loader_pkg::bank_t       rd_ba;
    logic [`SDRAM_WORD_AW-1:0]   rd_addr;
    logic [`PROM_AW-1:0]         prom_rd_addr;
    rom_loader_pkg::word_t       rd_data;
    rom_loader_pkg::byte_t       prom_rd_data;
    logic                        prog_busy;
    logic                        rd_check;
    logic                        rd_prom;
    int                          checks;
    int                          errors;
    logic [7:0]                  lfsr;
    logic                        timed_out;
    logic                        ended;

    rom_loader_top uut (
        .clk          (clk),
        .rst          (rst),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .rd_ba        (rd_ba),
        .rd_addr      (rd_addr),
        .prom_rd_addr (prom_rd_addr),
        .rd_data      (rd_data),
        .prom_rd_data (prom_rd_data),
        .prog_busy    (prog_busy)
    );

    rom_loader_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .prog_busy    (prog_busy),
        .rd_ba        (rd_ba),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data),
        .rd_check     (rd_check),
        .rd_prom      (rd_prom),
        .checks       (checks),
        .errors       (errors)
    );

    always #20 clk = ~clk;

    // taps of x^8 + x^6 + x^5 + x^4 + 1 with the shift going towards the MSB
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic random_byte(output rom_loader_pkg::byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (prog_busy && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (prog_busy) begin
            $display("timeout: prog_busy stayed high after a download byte");
            timed_out = 1'b1;
        end
    endtask

    task automatic send_entry(input logic [25:0] e);
        rom_loader_pkg::byte_t d;
        random_byte(d);
        @(posedge clk);
        #2;
        downloading = e[25];
        ioctl_addr  = e[24:0];
        ioctl_data  = d;
        ioctl_wr    = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
        repeat (GAP - 2) @(posedge clk);
        wait_idle();
    endtask

    task automatic read_entry(input logic [11:0] e);
        @(posedge clk);
        #2;
        rd_prom      = e[11];
        rd_ba        = e[10:9];
        rd_addr      = e[8:0];
        prom_rd_addr = e[7:0];
        rd_check     = 1'b1;
    endtask

    task automatic wait_checks();
        int cycles;
        cycles = 0;
        while (checks < RB_N && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (checks < RB_N) begin
            $display("timeout: only %0d of %0d readbacks were compared", checks, RB_N);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        rd_ba        = '0;
        rd_addr      = '0;
        prom_rd_addr = '0;
        rd_check     = 1'b0;
        rd_prom      = 1'b0;
        lfsr         = 8'd16;
        timed_out    = 1'b0;
        ended        = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < STIM_N && !timed_out; i++) begin
            send_entry(STIM[i]);
        end
        #2;
        downloading = 1'b0;
        for (int i = 0; i < RB_N && !timed_out; i++) begin
            read_entry(READBACK[i]);
        end
        @(posedge clk);
        #2;
        rd_check = 1'b0;
        if (!timed_out) begin
            wait_checks();
        end
        u_checker.print_summary();
        ended = 1'b1;
        if (timed_out || errors != 0) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    end

    // the overall time limit sits far above the expected run length
    initial begin
        #200000;
        $display("timeout: simulation ran past its time limit");
        ended = 1'b1;
        $display("*** FAILED ***");
        $finish;
    end

    // a run stopped by an assertion never reaches the verdict above
    final begin
        if (!ended) begin
            $display("*** FAILED ***");
        end
    end

endmodule
